// File: sim.f
src/keeper_pkg.sv
src/keeper_round_fsm.sv
src/shot_judge.sv
src/keeper_overlay.sv
src/gloves_keeper_top.sv
tb/tb_gloves_keeper.sv

// File: Bender.yml
package:
  name: gloves_keeper

sources:
  - src/keeper_pkg.sv
  - src/keeper_round_fsm.sv
  - src/shot_judge.sv
  - src/keeper_overlay.sv
  - src/gloves_keeper_top.sv
  - target: test
    files:
      - tb/tb_gloves_keeper.sv

// File: tb/tb_gloves_keeper.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the goalkeeper stage top level.
// Drives random rounds with short durations, follows them with a
// cycle-accurate model and compares status and video every cycle.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_gloves_keeper;

    localparam int CD_TICKS   = 20;
    localparam int SHOW       = 10;
    localparam int NUM_ROUNDS = 40;
    localparam int TIMEOUT    = NUM_ROUNDS * (CD_TICKS + 3 * SHOW + 50);
    localparam int H_TOTAL    = 1344;  // 1024x768 raster with blanking
    localparam int V_TOTAL    = 806;
    localparam int PIX_STEP   = 701;   // prime stride reaching the vsync lines in a short run

    logic                       clk;
    logic                       rst;
    keeper_pkg::game_state_t    game_state;
    logic                       enemy_done;
    keeper_pkg::shot_t          shot;
    keeper_pkg::cursor_t        cursor;
    keeper_pkg::vga_pixel_t     pix_in;
    keeper_pkg::vga_pixel_t     pix_out;
    keeper_pkg::keeper_status_t status;

    // reference model state
    keeper_pkg::keeper_phase_t  m_phase;
    int                         m_age;  // cycles already spent in m_phase
    keeper_pkg::keeper_status_t m_status;
    keeper_pkg::shot_t          m_saved;
    keeper_pkg::vga_pixel_t     m_s1_pix;
    logic                       m_s1_paint;
    logic [11:0]                m_s1_color;
    keeper_pkg::vga_pixel_t     m_out;
    logic                       model_live;

    int          cycles;
    int          rounds;
    int          n_goal;
    int          n_save;
    int          n_clamp;
    int          n_abort;
    int          n_paint;
    int unsigned pix_cnt;

    gloves_keeper_top #(
        .COUNTDOWN_TICKS (CD_TICKS),
        .SHOW_TICKS      (SHOW)
    ) dut_i (
        .clk        (clk),
        .rst        (rst),
        .game_state (game_state),
        .enemy_done (enemy_done),
        .shot       (shot),
        .cursor     (cursor),
        .pix_in     (pix_in),
        .pix_out    (pix_out),
        .status     (status)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_status(input keeper_pkg::keeper_status_t got,
                                input keeper_pkg::keeper_status_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch status: got %h expected %h (cycle %0d)",
                                     got, exp, cycles));
        end
    endtask

    task automatic check_pixel(input keeper_pkg::vga_pixel_t got,
                               input keeper_pkg::vga_pixel_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch pix_out: got %h expected %h (cycle %0d)",
                                     got, exp, cycles));
        end
    endtask

    // total cycles a phase lasts before it moves on
    function automatic int phase_len(input keeper_pkg::keeper_phase_t ph);
        case (ph)
            keeper_pkg::PH_COUNTDOWN: return CD_TICKS + 1;
            keeper_pkg::PH_GOAL,
            keeper_pkg::PH_SAVE,
            keeper_pkg::PH_TERMINATE: return SHOW + 1;
            default:                  return 1;
        endcase
    endfunction

    function automatic logic inside_box(input int h, input int v, input keeper_pkg::shot_t s);
        return (h >= int'(s.x)) && (h <= int'(s.x) + int'(keeper_pkg::BOX_SIZE)) &&
               (v >= int'(s.y)) && (v <= int'(s.y) + int'(keeper_pkg::BOX_SIZE));
    endfunction

    function automatic logic judge_save(input keeper_pkg::shot_t s,
                                        input keeper_pkg::cursor_t c);
        logic edge_hit;
        edge_hit = (s.x == 10'd0) || (s.x == 10'd1000) || (s.y == 10'd0) || (s.y == 10'd738);
        return edge_hit || inside_box(int'(c.x), int'(c.y), s);
    endfunction

    task automatic reset_model();
        m_phase    = keeper_pkg::PH_IDLE;
        m_age      = 0;
        m_status   = '0;
        m_saved    = '0;
        m_s1_pix   = '0;
        m_s1_paint = 1'b0;
        m_s1_color = '0;
        m_out      = '0;
    endtask

    task automatic step_model();
        keeper_pkg::keeper_phase_t nxt;
        logic                      leave;
        leave = (m_age + 1 >= phase_len(m_phase));
        nxt   = m_phase;
        case (m_phase)
            keeper_pkg::PH_IDLE: begin
                if (game_state == keeper_pkg::GS_KEEPER) nxt = keeper_pkg::PH_ENGAGE;
            end
            keeper_pkg::PH_ENGAGE: begin
                if (game_state != keeper_pkg::GS_KEEPER) begin
                    nxt = keeper_pkg::PH_IDLE;
                    n_abort++;
                end else if (enemy_done) begin
                    nxt = keeper_pkg::PH_COUNTDOWN;
                    if (shot.y > 10'd767) n_clamp++;
                end
            end
            keeper_pkg::PH_COUNTDOWN: if (leave) nxt = keeper_pkg::PH_RESULT;
            keeper_pkg::PH_RESULT: begin
                nxt = judge_save(m_saved, cursor) ? keeper_pkg::PH_SAVE : keeper_pkg::PH_GOAL;
            end
            keeper_pkg::PH_GOAL,
            keeper_pkg::PH_SAVE:      if (leave) nxt = keeper_pkg::PH_TERMINATE;
            keeper_pkg::PH_TERMINATE: if (leave) nxt = keeper_pkg::PH_IDLE;
            default:                  nxt = keeper_pkg::PH_IDLE;
        endcase

        // stage two takes the old stage one before stage one refills
        m_out.timing = m_s1_pix.timing;
        m_out.rgb    = m_s1_paint ? m_s1_color : m_s1_pix.rgb;
        m_s1_pix     = pix_in;
        m_s1_paint   = inside_box(int'(pix_in.timing.hcount), int'(pix_in.timing.vcount),
                                  m_saved);
        case (m_phase)
            keeper_pkg::PH_COUNTDOWN: m_s1_color = 12'h00F;
            keeper_pkg::PH_GOAL:      m_s1_color = 12'hF00;
            keeper_pkg::PH_SAVE:      m_s1_color = 12'h0F0;
            default:                  m_s1_paint = 1'b0;
        endcase
        if (m_s1_paint) n_paint++;

        case (m_phase)
            keeper_pkg::PH_ENGAGE: begin
                m_saved.x = shot.x;
                m_saved.y = (shot.y > 10'd767) ? 10'd767 : shot.y;
            end
            keeper_pkg::PH_COUNTDOWN,
            keeper_pkg::PH_RESULT,
            keeper_pkg::PH_GOAL,
            keeper_pkg::PH_SAVE: ;  // held
            default: m_saved = '0;
        endcase

        m_status.is_scored  = (nxt == keeper_pkg::PH_GOAL);
        m_status.round_done = (nxt == keeper_pkg::PH_GOAL) || (nxt == keeper_pkg::PH_SAVE);
        m_status.end_gk     = (m_phase == keeper_pkg::PH_TERMINATE) &&
                              (nxt == keeper_pkg::PH_IDLE);
        if (m_status.end_gk) rounds++;
        if (m_phase == keeper_pkg::PH_RESULT && nxt == keeper_pkg::PH_GOAL) n_goal++;
        if (m_phase == keeper_pkg::PH_RESULT && nxt == keeper_pkg::PH_SAVE) n_save++;
        m_age   = (nxt == m_phase) ? m_age + 1 : 0;
        m_phase = nxt;
    endtask

    task automatic drive_inputs();
        keeper_pkg::shot_t      nshot;
        keeper_pkg::cursor_t    ncur;
        keeper_pkg::vga_pixel_t npix;
        logic [1:0]             gs_pick;
        int                     hpos;
        int                     vpos;
        int                     mode;
        if ($urandom_range(0, 39) == 0) begin
            gs_pick = 2'($urandom_range(0, 2));
            if (gs_pick == 2'd2) gs_pick = 2'd3;  // anything but keeper
            game_state <= keeper_pkg::game_state_t'(gs_pick);
        end else begin
            game_state <= keeper_pkg::GS_KEEPER;
        end
        enemy_done <= ($urandom_range(0, 7) == 0);

        mode    = int'($urandom_range(0, 9));
        nshot.x = 10'($urandom_range(0, 1023));
        nshot.y = 10'($urandom_range(0, 767));
        case (mode)
            0:       nshot.x = 10'd0;
            1:       nshot.x = 10'd1000;
            2:       nshot.y = 10'd0;
            3:       nshot.y = 10'd738;
            4, 5:    nshot.y = 10'($urandom_range(768, 1023));
            default: ;
        endcase
        shot <= nshot;

        // half the gloves land on or just around the box
        if ($urandom_range(0, 1) == 1) begin
            ncur.x = 12'(int'(m_saved.x) + int'($urandom_range(0, 102)) - 1);
            ncur.y = 12'(int'(m_saved.y) + int'($urandom_range(0, 102)) - 1);
        end else begin
            ncur.x = 12'($urandom);
            ncur.y = 12'($urandom);
        end
        cursor <= ncur;

        pix_cnt += PIX_STEP;
        hpos = int'(pix_cnt % H_TOTAL);
        vpos = int'((pix_cnt / H_TOTAL) % V_TOTAL);
        npix.timing.hcount = 11'(hpos);
        npix.timing.vcount = 11'(vpos);
        npix.timing.hsync  = (hpos >= 1048) && (hpos < 1184);
        npix.timing.vsync  = (vpos >= 771) && (vpos < 777);
        npix.timing.hblnk  = (hpos >= 1024);
        npix.timing.vblnk  = (vpos >= 768);
        npix.rgb           = 12'($urandom);
        if ($urandom_range(0, 1) == 1) begin
            npix.timing.hcount = 11'(int'(m_saved.x) + int'($urandom_range(0, 104)) - 2);
            npix.timing.vcount = 11'(int'(m_saved.y) + int'($urandom_range(0, 104)) - 2);
        end
        pix_in <= npix;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            reset_model();
            model_live = 1'b1;
        end else if (model_live) begin
            step_model();
            cycles++;
            if (cycles >= TIMEOUT) begin
                report_failure($sformatf("Timeout: only %0d of %0d rounds finished",
                                         rounds, NUM_ROUNDS));
            end
        end
        drive_inputs();
    end

    // outputs are settled half a period after the edge
    always @(negedge clk) begin
        if (model_live) begin
            check_status(status, m_status);
            check_pixel(pix_out, m_out);
        end
    end

    initial begin
        void'($urandom(48));
        rst        = 1'b1;
        game_state = keeper_pkg::GS_KEEPER;
        enemy_done = 1'b0;
        shot       = '0;
        cursor     = '0;
        pix_in     = '0;
        model_live = 1'b0;
        cycles     = 0;
        rounds     = 0;
        n_goal     = 0;
        n_save     = 0;
        n_clamp    = 0;
        n_abort    = 0;
        n_paint    = 0;
        pix_cnt    = 0;
        reset_model();

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        wait (rounds >= NUM_ROUNDS);
        repeat (3) @(posedge clk);
        if (n_goal == 0 || n_save == 0 || n_clamp == 0 || n_abort == 0 || n_paint == 0) begin
            report_failure($sformatf({"Stimulus missed a case: goals %0d saves %0d ",
                                      "clamps %0d aborts %0d painted %0d"},
                                     n_goal, n_save, n_clamp, n_abort, n_paint));
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// File: src/gloves_keeper_top.sv
////////////////////////////////////////////////////////////////////////////
// Goalkeeper stage of the two-player penalty game.
// Connects the round sequencer, the shot judge and the video overlay.
// Durations are parameters so that simulation can shorten the round.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module gloves_keeper_top #(
    parameter logic [keeper_pkg::TICK_W-1:0] COUNTDOWN_TICKS = keeper_pkg::COUNTDOWN_TICKS_DEF,
    parameter logic [keeper_pkg::TICK_W-1:0] SHOW_TICKS      = keeper_pkg::SHOW_TICKS_DEF
) (
    input  logic                       clk,
    input  logic                       rst,
    input  keeper_pkg::game_state_t    game_state,
    input  logic                       enemy_done,   // opponent has fired
    input  keeper_pkg::shot_t          shot,
    input  keeper_pkg::cursor_t        cursor,
    input  keeper_pkg::vga_pixel_t     pix_in,
    output keeper_pkg::vga_pixel_t     pix_out,
    output keeper_pkg::keeper_status_t status
);

    keeper_pkg::keeper_phase_t phase;
    keeper_pkg::shot_t         saved_shot;
    keeper_pkg::verdict_t      verdict;

    keeper_round_fsm #(
        .COUNTDOWN_TICKS (COUNTDOWN_TICKS),
        .SHOW_TICKS      (SHOW_TICKS)
    ) u_round_fsm (
        .clk        (clk),
        .rst        (rst),
        .game_state (game_state),
        .enemy_done (enemy_done),
        .verdict    (verdict),
        .phase      (phase),
        .status     (status)
    );

    shot_judge u_shot_judge (
        .clk        (clk),
        .rst        (rst),
        .phase      (phase),
        .shot       (shot),
        .cursor     (cursor),
        .saved_shot (saved_shot),
        .verdict    (verdict)
    );

    keeper_overlay u_overlay (
        .clk        (clk),
        .rst        (rst),
        .phase      (phase),
        .saved_shot (saved_shot),
        .pix_in     (pix_in),
        .pix_out    (pix_out)
    );

endmodule

// File: src/keeper_overlay.sv
////////////////////////////////////////////////////////////////////////////
// Target box overlay on the video stream.
// Two register stages: the first samples the pixel and decides whether it
// falls in the box during a painted phase, the second swaps the colour.
// Every timing field leaves exactly two cycles after it entered.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module keeper_overlay (
    input  logic                      clk,
    input  logic                      rst,
    input  keeper_pkg::keeper_phase_t phase,
    input  keeper_pkg::shot_t         saved_shot,
    input  keeper_pkg::vga_pixel_t    pix_in,
    output keeper_pkg::vga_pixel_t    pix_out
);

    keeper_pkg::vga_pixel_t pix_s1;
    logic                   paint_s1;
    logic [11:0]            color_s1;
    logic [10:0]            box_x_hi;
    logic [10:0]            box_y_hi;
    logic                   in_box;
    logic                   painted_phase;
    logic [11:0]            phase_color;

    assign box_x_hi = {1'b0, saved_shot.x} + 11'(keeper_pkg::BOX_SIZE);
    assign box_y_hi = {1'b0, saved_shot.y} + 11'(keeper_pkg::BOX_SIZE);

    assign in_box = (pix_in.timing.hcount >= {1'b0, saved_shot.x}) &&
                    (pix_in.timing.hcount <= box_x_hi) &&
                    (pix_in.timing.vcount >= {1'b0, saved_shot.y}) &&
                    (pix_in.timing.vcount <= box_y_hi);

    always_comb begin
        painted_phase = 1'b1;
        case (phase)
            keeper_pkg::PH_COUNTDOWN: phase_color = keeper_pkg::COLOR_TARGET;
            keeper_pkg::PH_GOAL:      phase_color = keeper_pkg::COLOR_GOAL;
            keeper_pkg::PH_SAVE:      phase_color = keeper_pkg::COLOR_SAVE;
            default: begin
                painted_phase = 1'b0;
                phase_color   = pix_in.rgb;  // box not shown
            end
        endcase
    end

    // stage one
    always_ff @(posedge clk) begin
        if (rst) begin
            pix_s1   <= '0;
            paint_s1 <= 1'b0;
            color_s1 <= '0;
        end else begin
            pix_s1   <= pix_in;
            paint_s1 <= in_box && painted_phase;
            color_s1 <= phase_color;
        end
    end

    // stage two
    always_ff @(posedge clk) begin
        if (rst) begin
            pix_out <= '0;
        end else begin
            pix_out.timing <= pix_s1.timing;
            pix_out.rgb    <= paint_s1 ? color_s1 : pix_s1.rgb;
        end
    end

    // sync comes out exactly two cycles late
    sync_delay: assert property (@(posedge clk) disable iff (rst)
        !$past(rst, 1) && !$past(rst, 2) |->
        {pix_out.timing.hsync, pix_out.timing.vsync} ==
        $past({pix_in.timing.hsync, pix_in.timing.vsync}, 2));

endmodule

// File: src/shot_judge.sv
////////////////////////////////////////////////////////////////////////////
// Shot register and goal or save decision.
// Loads the opponent's shot with y clamped while the round is engaged,
// holds it through the result display and judges it against the glove.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module shot_judge (
    input  logic                      clk,
    input  logic                      rst,
    input  keeper_pkg::keeper_phase_t phase,
    input  keeper_pkg::shot_t         shot,
    input  keeper_pkg::cursor_t       cursor,
    output keeper_pkg::shot_t         saved_shot,
    output keeper_pkg::verdict_t      verdict
);

    keeper_pkg::shot_t shot_clamped;
    logic [11:0]       box_x_hi;
    logic [11:0]       box_y_hi;
    logic              on_edge;
    logic              glove_hit;

    always_comb begin
        shot_clamped.x = shot.x;  // a 10-bit x is always on screen
        if (shot.y > keeper_pkg::SHOT_Y_MAX) begin
            shot_clamped.y = keeper_pkg::SHOT_Y_MAX;
        end else begin
            shot_clamped.y = shot.y;
        end
    end

    always_ff @(posedge clk) begin
        case (phase)
            keeper_pkg::PH_ENGAGE: begin
                saved_shot <= shot_clamped;  // follows the shot until it is fired
            end
            keeper_pkg::PH_COUNTDOWN,
            keeper_pkg::PH_RESULT,
            keeper_pkg::PH_GOAL,
            keeper_pkg::PH_SAVE: begin
                saved_shot <= saved_shot;
            end
            default: begin
                saved_shot <= '0;
            end
        endcase
    end

    assign box_x_hi = {2'b00, saved_shot.x} + 12'(keeper_pkg::BOX_SIZE);
    assign box_y_hi = {2'b00, saved_shot.y} + 12'(keeper_pkg::BOX_SIZE);

    // shots on the frame edges are always saved
    assign on_edge = (saved_shot.x == 10'd0) ||
                     (saved_shot.x == keeper_pkg::EDGE_X_RIGHT) ||
                     (saved_shot.y == 10'd0) ||
                     (saved_shot.y == keeper_pkg::EDGE_Y_BOTTOM);

    assign glove_hit = (cursor.x >= {2'b00, saved_shot.x}) && (cursor.x <= box_x_hi) &&
                       (cursor.y >= {2'b00, saved_shot.y}) && (cursor.y <= box_y_hi);

    always_comb begin
        if (on_edge || glove_hit) begin
            verdict = keeper_pkg::V_SAVE;
        end else begin
            verdict = keeper_pkg::V_GOAL;
        end
    end

    saved_y_clamped: assert property (@(posedge clk) disable iff (rst)
        saved_shot.y <= keeper_pkg::SHOT_Y_MAX);

endmodule

// File: src/keeper_round_fsm.sv
////////////////////////////////////////////////////////////////////////////
// Round sequencer of the goalkeeper stage.
// Walks idle, engage, countdown, result, goal or save and terminate with
// one shared duration counter. Status bits are registered with the phase
// so they cover exactly the goal, save and end-of-round cycles.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module keeper_round_fsm #(
    parameter logic [keeper_pkg::TICK_W-1:0] COUNTDOWN_TICKS = keeper_pkg::COUNTDOWN_TICKS_DEF,
    parameter logic [keeper_pkg::TICK_W-1:0] SHOW_TICKS      = keeper_pkg::SHOW_TICKS_DEF
) (
    input  logic                       clk,
    input  logic                       rst,
    input  keeper_pkg::game_state_t    game_state,
    input  logic                       enemy_done,
    input  keeper_pkg::verdict_t       verdict,
    output keeper_pkg::keeper_phase_t  phase,
    output keeper_pkg::keeper_status_t status
);

    keeper_pkg::keeper_phase_t     phase_nxt;
    keeper_pkg::keeper_status_t    status_nxt;
    logic [keeper_pkg::TICK_W-1:0] tick_cnt;
    logic [keeper_pkg::TICK_W-1:0] tick_cnt_nxt;
    logic                          timed;
    logic                          countdown_over;
    logic                          show_over;

    assign countdown_over = (tick_cnt == COUNTDOWN_TICKS);
    assign show_over      = (tick_cnt == SHOW_TICKS);

    // phases that run on the duration counter
    assign timed = (phase == keeper_pkg::PH_COUNTDOWN) ||
                   (phase == keeper_pkg::PH_GOAL)      ||
                   (phase == keeper_pkg::PH_SAVE)      ||
                   (phase == keeper_pkg::PH_TERMINATE);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= keeper_pkg::PH_IDLE;
            status   <= '0;
            tick_cnt <= '0;
        end else begin
            phase    <= phase_nxt;
            status   <= status_nxt;
            tick_cnt <= tick_cnt_nxt;
        end
    end

    always_comb begin
        phase_nxt = phase;
        case (phase)
            keeper_pkg::PH_IDLE: begin
                if (game_state == keeper_pkg::GS_KEEPER) begin
                    phase_nxt = keeper_pkg::PH_ENGAGE;
                end
            end
            keeper_pkg::PH_ENGAGE: begin  // wait for the opponent's shot
                if (game_state != keeper_pkg::GS_KEEPER) begin
                    phase_nxt = keeper_pkg::PH_IDLE;
                end else if (enemy_done) begin
                    phase_nxt = keeper_pkg::PH_COUNTDOWN;
                end
            end
            keeper_pkg::PH_COUNTDOWN: begin
                if (countdown_over) begin
                    phase_nxt = keeper_pkg::PH_RESULT;
                end
            end
            keeper_pkg::PH_RESULT: begin
                if (verdict == keeper_pkg::V_SAVE) begin
                    phase_nxt = keeper_pkg::PH_SAVE;
                end else begin
                    phase_nxt = keeper_pkg::PH_GOAL;
                end
            end
            keeper_pkg::PH_GOAL,
            keeper_pkg::PH_SAVE: begin
                if (show_over) begin
                    phase_nxt = keeper_pkg::PH_TERMINATE;
                end
            end
            keeper_pkg::PH_TERMINATE: begin
                if (show_over) begin
                    phase_nxt = keeper_pkg::PH_IDLE;
                end
            end
            default: begin
                phase_nxt = keeper_pkg::PH_IDLE;  // illegal encoding
            end
        endcase
    end

    always_comb begin
        // restart on every phase change
        if (!timed || (phase_nxt != phase)) begin
            tick_cnt_nxt = '0;
        end else begin
            tick_cnt_nxt = tick_cnt + 1'b1;
        end

        status_nxt.is_scored  = (phase_nxt == keeper_pkg::PH_GOAL);
        status_nxt.round_done = (phase_nxt == keeper_pkg::PH_GOAL) ||
                                (phase_nxt == keeper_pkg::PH_SAVE);
        status_nxt.end_gk     = (phase == keeper_pkg::PH_TERMINATE) &&
                                (phase_nxt == keeper_pkg::PH_IDLE);
    end

    // end pulse lasts a single cycle
    end_gk_single: assert property (@(posedge clk) disable iff (rst)
        status.end_gk |=> !status.end_gk);

    scored_in_round: assert property (@(posedge clk) disable iff (rst)
        status.is_scored |-> status.round_done);

endmodule

// File: src/keeper_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types and constants of the goalkeeper stage.
// Holds the game and round encodings, the shot, cursor and video structs,
// the target box geometry, the phase colours and the default durations.
// Files refer to these by scoped names.
////////////////////////////////////////////////////////////////////////////

package keeper_pkg;

    localparam int TICK_W = 26;  // wide enough for the 0.5 s window at 65 MHz

    // defaults for a 65 MHz pixel clock
    localparam logic [TICK_W-1:0] COUNTDOWN_TICKS_DEF = 26'd32_500_000;  // 0.5 s
    localparam logic [TICK_W-1:0] SHOW_TICKS_DEF      = 26'd16_250_000;  // 0.25 s

    // target box geometry
    localparam int unsigned BOX_SIZE      = 100;
    localparam logic [9:0]  SHOT_Y_MAX    = 10'd767;
    localparam logic [9:0]  EDGE_X_RIGHT  = 10'd1000;
    localparam logic [9:0]  EDGE_Y_BOTTOM = 10'd738;

    localparam logic [11:0] COLOR_TARGET = 12'h0_0_F;  // blue
    localparam logic [11:0] COLOR_GOAL   = 12'hF_0_0;  // red
    localparam logic [11:0] COLOR_SAVE   = 12'h0_F_0;  // green

    typedef enum logic [1:0] {
        GS_MENU,
        GS_SHOOTER,
        GS_KEEPER,
        GS_OVER
    } game_state_t;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_ENGAGE,
        PH_COUNTDOWN,
        PH_RESULT,
        PH_GOAL,
        PH_SAVE,
        PH_TERMINATE
    } keeper_phase_t;

    typedef enum logic {
        V_GOAL,
        V_SAVE
    } verdict_t;

    // opponent's shot in screen coordinates
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
    } shot_t;

    // glove position
    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
    } cursor_t;

    typedef struct packed {
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
    } vga_timing_t;

    typedef struct packed {
        vga_timing_t timing;
        logic [11:0] rgb;
    } vga_pixel_t;

    typedef struct packed {
        logic is_scored;
        logic round_done;
        logic end_gk;
    } keeper_status_t;

endpackage
